// File: runSim.sh
#!/bin/sh
# builds and runs the LCD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tbLcdController -Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/VtbLcdController
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// File: source/lcdBusTiming.sv
`default_nettype none

module lcdBusTiming
#(
    parameter int pulseCycles     = 26,
    parameter int shortWaitCycles = 2500,
    parameter int midWaitCycles   = 7500,
    parameter int longWaitCycles  = 250000
)
(
    input  logic              clk,
    input  logic              lcdOnIn,
    lcdCmdIf.timing           cmd,
    output lcdPkg::charCode_t lcdBus,
    output logic              lcdRsSelect,
    output logic              lcdEnableOut
);

    typedef enum logic [1:0] {
        idle,
        setup,
        pulse,
        settle
    } timingState_t;

    localparam int longestWait = (longWaitCycles > midWaitCycles) ?
        ((longWaitCycles > shortWaitCycles) ? longWaitCycles : shortWaitCycles) :
        ((midWaitCycles > shortWaitCycles) ? midWaitCycles : shortWaitCycles);
    localparam int maxCycles = (pulseCycles > longestWait) ? pulseCycles : longestWait;
    localparam int cntWidth  = $clog2(maxCycles + 1);

    localparam logic [cntWidth-1:0] pulseLast = cntWidth'(pulseCycles);

    timingState_t        state;
    logic [cntWidth-1:0] counter;
    logic [cntWidth-1:0] settleLen;
    lcdPkg::waitKind_t   waitLatched;

    // settle length of the command in flight
    always_comb
    begin
        case (waitLatched)
            lcdPkg::waitMid:  settleLen = cntWidth'(midWaitCycles);
            lcdPkg::waitLong: settleLen = cntWidth'(longWaitCycles);
            default:          settleLen = cntWidth'(shortWaitCycles);
        endcase
    end

    // last settle cycle
    assign cmd.done = (state == settle) && (counter == settleLen);

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            state        <= idle;
            counter      <= '0;
            lcdBus       <= '0;
            lcdRsSelect  <= 1'b0;
            lcdEnableOut <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    // latch the command, bus held until the next one
                    if (cmd.issue)
                    begin
                        lcdBus      <= cmd.cmdByte;
                        lcdRsSelect <= cmd.rsSel;
                        state       <= setup;
                    end
                end
                setup:
                begin
                    lcdEnableOut <= 1'b1;
                    counter      <= '0;
                    state        <= pulse;
                end
                pulse:
                begin
                    if (counter == pulseLast)
                    begin
                        lcdEnableOut <= 1'b0;
                        counter      <= '0;
                        state        <= settle;
                    end
                    else
                        counter <= counter + 1'b1;
                end
                default:
                begin
                    if (cmd.done)
                        state <= idle;
                    else
                        counter <= counter + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle && cmd.issue)
            waitLatched <= cmd.waitKind;
    end

endmodule

`default_nettype wire

// File: source/lcdCharBuffer.sv
`default_nettype none

module lcdCharBuffer
(
    input  logic              clk,
    input  lcdPkg::charAddr_t writeAddr,
    input  lcdPkg::charCode_t charCode,
    input  lcdPkg::charAddr_t readAddr,
    output lcdPkg::charCode_t readData
);

    // one character code per display cell
    lcdPkg::charCode_t charMem [lcdPkg::bufferDepth];

    // written on every clock from outside
    always_ff @(posedge clk)
    begin
        charMem[writeAddr] <= charCode;
    end

    // registered read, valid one clock after readAddr
    always_ff @(posedge clk)
    begin
        readData <= charMem[readAddr];
    end

endmodule

`default_nettype wire

// File: source/lcdCmdIf.sv
`default_nettype none

// one LCD command in flight, sequencer to bus timing
interface lcdCmdIf;

    logic              issue;
    lcdPkg::charCode_t cmdByte;
    // 0 = command, 1 = data
    logic              rsSel;
    lcdPkg::waitKind_t waitKind;
    logic              done;

    modport sequencer
    (
        output issue,
        output cmdByte,
        output rsSel,
        output waitKind,
        input  done
    );

    modport timing
    (
        input  issue,
        input  cmdByte,
        input  rsSel,
        input  waitKind,
        output done
    );

endinterface

`default_nettype wire

// File: source/lcdController.sv
`default_nettype none

module lcdController
#(
    parameter int pulseCycles     = 26,
    parameter int shortWaitCycles = 2500,
    parameter int midWaitCycles   = 7500,
    parameter int longWaitCycles  = 250000,
    parameter int powerOnCycles   = 1000000
)
(
    input  logic              clk,
    input  logic              lcdOnIn,
    input  lcdPkg::charAddr_t writeAddr,
    input  lcdPkg::charCode_t charCode,
    output lcdPkg::charCode_t lcdBus,
    output logic              lcdOnOut,
    output logic              lcdReadWriteSel,
    output logic              lcdRsSelect,
    output logic              lcdEnableOut
);

    lcdPkg::charAddr_t readAddr;
    lcdPkg::charCode_t readData;

    lcdCmdIf cmdLink();

    // only writes go to the LCD
    assign lcdReadWriteSel = 1'b0;
    assign lcdOnOut        = lcdOnIn;

    lcdCharBuffer u_charBuffer
    (
        .clk       (clk),
        .writeAddr (writeAddr),
        .charCode  (charCode),
        .readAddr  (readAddr),
        .readData  (readData)
    );

    lcdSequencer #(
        .powerOnCycles (powerOnCycles)
    ) u_sequencer (
        .clk      (clk),
        .lcdOnIn  (lcdOnIn),
        .cmd      (cmdLink),
        .readData (readData),
        .readAddr (readAddr)
    );

    lcdBusTiming #(
        .pulseCycles     (pulseCycles),
        .shortWaitCycles (shortWaitCycles),
        .midWaitCycles   (midWaitCycles),
        .longWaitCycles  (longWaitCycles)
    ) u_busTiming (
        .clk          (clk),
        .lcdOnIn      (lcdOnIn),
        .cmd          (cmdLink),
        .lcdBus       (lcdBus),
        .lcdRsSelect  (lcdRsSelect),
        .lcdEnableOut (lcdEnableOut)
    );

endmodule

`default_nettype wire

// File: source/lcdPkg.sv
`default_nettype none

package lcdPkg;

    // one character code or one command byte
    typedef logic [7:0] charCode_t;

    // buffer address, 0 to 31
    typedef logic [4:0] charAddr_t;

    localparam int bufferDepth = 32;

    // command bytes of the usual 8-bit LCD command set
    typedef enum logic [7:0] {
        functionSet     = 8'h38,
        displayOff      = 8'h08,
        displayOn       = 8'h0C,
        displayClear    = 8'h01,
        entryModeSet    = 8'h06,
        cursorShift     = 8'h14,
        cursorHome      = 8'h02,
        // DDRAM address bases, first and second line
        setAddress      = 8'h80,
        setAddressLine2 = 8'hC0
    } lcdOpcode_t;

    // settling wait after a command
    typedef enum logic [1:0] {
        waitShort,
        waitMid,
        waitLong
    } waitKind_t;

    // sequencer progress
    typedef enum logic [2:0] {
        powerOn,
        initCmd,
        refreshAddr,
        refreshData,
        refreshCursor
    } seqState_t;

endpackage

`default_nettype wire

// File: source/lcdSequencer.sv
`default_nettype none

module lcdSequencer
#(
    parameter int powerOnCycles = 1000000
)
(
    input  logic              clk,
    input  logic              lcdOnIn,
    lcdCmdIf.sequencer        cmd,
    input  lcdPkg::charCode_t readData,
    output lcdPkg::charAddr_t readAddr
);

    localparam int powerWidth = $clog2(powerOnCycles + 1);
    localparam logic [powerWidth-1:0] powerLast = powerWidth'(powerOnCycles);
    // index of the last init command
    localparam logic [3:0] initLast = 4'd8;

    lcdPkg::seqState_t     state;
    lcdPkg::seqState_t     nextState;
    logic [powerWidth-1:0] powerCount;
    logic [3:0]            initIndex;
    lcdPkg::charAddr_t     addrCount;
    lcdPkg::charAddr_t     targetAddr;
    logic                  launch;
    lcdPkg::charCode_t     nextByte;
    logic                  nextRs;
    lcdPkg::waitKind_t     nextWait;

    // init order: function set x4, display off, clear, entry mode, display on, clear
    function automatic lcdPkg::charCode_t initByte(input logic [3:0] index);
        case (index)
            4'd4:    return lcdPkg::displayOff;
            4'd5:    return lcdPkg::displayClear;
            4'd6:    return lcdPkg::entryModeSet;
            4'd7:    return lcdPkg::displayOn;
            4'd8:    return lcdPkg::displayClear;
            default: return lcdPkg::functionSet;
        endcase
    endfunction

    function automatic lcdPkg::waitKind_t initWait(input logic [3:0] index);
        case (index)
            4'd0:    return lcdPkg::waitLong;
            4'd1,
            4'd2,
            4'd3:    return lcdPkg::waitMid;
            4'd4,
            4'd7:    return lcdPkg::waitShort;
            default: return lcdPkg::waitLong;
        endcase
    endfunction

    // first line for 0..15, second line for 16..31
    function automatic lcdPkg::charCode_t addrByte(input lcdPkg::charAddr_t addr);
        if (addr[4])
            return lcdPkg::setAddressLine2 | {4'h0, addr[3:0]};
        else
            return lcdPkg::setAddress | {3'b000, addr};
    endfunction

    // address of the next set-address command, wraps 31 to 0
    assign targetAddr = (state == lcdPkg::refreshCursor) ? addrCount + 1'b1 : addrCount;

    // the buffer reads the cell being refreshed
    assign readAddr = addrCount;

    // new command after the power-on wait, then one cycle after each done
    assign launch = (state == lcdPkg::powerOn) ? (powerCount == powerLast) : cmd.done;

    always_comb
    begin
        nextState = state;
        nextByte  = initByte(4'd0);
        nextRs    = 1'b0;
        nextWait  = initWait(4'd0);
        case (state)
            lcdPkg::powerOn:
            begin
                nextState = lcdPkg::initCmd;
            end
            lcdPkg::initCmd:
            begin
                if (initIndex == initLast)
                begin
                    nextState = lcdPkg::refreshAddr;
                    nextByte  = addrByte(targetAddr);
                    nextWait  = lcdPkg::waitShort;
                end
                else
                begin
                    nextByte = initByte(initIndex + 1'b1);
                    nextWait = initWait(initIndex + 1'b1);
                end
            end
            lcdPkg::refreshAddr:
            begin
                nextState = lcdPkg::refreshData;
                nextByte  = readData;
                nextRs    = 1'b1;
                nextWait  = lcdPkg::waitShort;
            end
            lcdPkg::refreshData:
            begin
                nextState = lcdPkg::refreshCursor;
                nextWait  = lcdPkg::waitShort;
                // home at the last cell, otherwise step right
                if (addrCount == lcdPkg::charAddr_t'(lcdPkg::bufferDepth - 1))
                    nextByte = lcdPkg::cursorHome;
                else
                    nextByte = lcdPkg::cursorShift;
            end
            default:
            begin
                nextState = lcdPkg::refreshAddr;
                nextByte  = addrByte(targetAddr);
                nextWait  = lcdPkg::waitShort;
            end
        endcase
    end

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            state      <= lcdPkg::powerOn;
            powerCount <= '0;
            initIndex  <= '0;
            addrCount  <= '0;
            cmd.issue  <= 1'b0;
        end
        else
        begin
            cmd.issue <= launch;
            if (state == lcdPkg::powerOn && !launch)
                powerCount <= powerCount + 1'b1;
            if (launch)
            begin
                state <= nextState;
                if (state == lcdPkg::initCmd)
                    initIndex <= initIndex + 1'b1;
                if (nextState == lcdPkg::refreshAddr)
                    addrCount <= targetAddr;
            end
        end
    end

    // command fields, valid together with issue
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            cmd.cmdByte  <= nextByte;
            cmd.rsSel    <= nextRs;
            cmd.waitKind <= nextWait;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
source/lcdPkg.sv
source/lcdCmdIf.sv
source/lcdCharBuffer.sv
source/lcdSequencer.sv
source/lcdBusTiming.sv
source/lcdController.sv
testbench/tbLcdController.sv

// File: testbench/lcdVectors.txt
// 32 character codes for cells 0 to 31, then the nine init command bytes
48
65
6C
6C
6F
20
4C
43
44
20
77
6F
72
6C
64
21
30
31
32
33
34
35
36
37
38
39
41
42
43
44
45
46
// init: function set x4, display off, clear, entry mode, display on, clear
38
38
38
38
08
01
06
0C
01

// File: testbench/tbLcdController.sv
`default_nettype none

module tbLcdController;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int pulseCycles     = 3;
    localparam int shortWaitCycles = 5;
    localparam int midWaitCycles   = 7;
    localparam int longWaitCycles  = 11;
    localparam int powerOnCycles   = 20;
    localparam int resetCycles     = 8;
    localparam int initCount       = 9;
    localparam int charCount       = 32;
    localparam int passCommands    = 3 * charCount;
    // one command at the long wait including setup and handover
    localparam int longCmdCycles   = pulseCycles + longWaitCycles + 4;
    localparam int watchdogCycles  = 2 * (2 * resetCycles + 2 * (powerOnCycles + 3)
        + 2 * initCount * longCmdCycles + 3 * passCommands * longCmdCycles);

    logic              clk = 1'b1;
    logic              lcdOnIn;
    lcdPkg::charAddr_t writeAddr;
    lcdPkg::charCode_t charCode;
    lcdPkg::charCode_t lcdBus;
    logic              lcdOnOut;
    logic              lcdReadWriteSel;
    logic              lcdRsSelect;
    logic              lcdEnableOut;

    // characters first, then the init bytes
    logic [7:0]  vectorMem [0:charCount+initCount-1];
    logic [7:0]  charModel [0:charCount-1];
    int unsigned seedValue;

    // one captured command per enable pulse
    logic [7:0] capByteQ [$];
    logic       capRsQ [$];
    int         highWidthQ [$];
    int         lowGapQ [$];
    int         fallCount  = 0;
    int         gapCount   = 0;
    int         highCount  = 0;
    int         lowCount   = 0;
    bit         enablePrev = 1'b0;
    bit         haveFall   = 1'b0;

    lcdController #(
        .pulseCycles     (pulseCycles),
        .shortWaitCycles (shortWaitCycles),
        .midWaitCycles   (midWaitCycles),
        .longWaitCycles  (longWaitCycles),
        .powerOnCycles   (powerOnCycles)
    ) u_dut (
        .clk             (clk),
        .lcdOnIn         (lcdOnIn),
        .writeAddr       (writeAddr),
        .charCode        (charCode),
        .lcdBus          (lcdBus),
        .lcdOnOut        (lcdOnOut),
        .lcdReadWriteSel (lcdReadWriteSel),
        .lcdRsSelect     (lcdRsSelect),
        .lcdEnableOut    (lcdEnableOut)
    );

    always #50 clk = ~clk;

    task automatic checkValue(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("ERROR at %0t: %s expected 0x%0h, actual 0x%0h",
                $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // set-address byte with the first line at 0x80 and the second at 0xC0
    function automatic int addressByte(input int addr);
        if (addr < 16)
            return 'h80 + addr;
        return 'hC0 + addr - 16;
    endfunction

    // later function sets settle shorter than the first one
    function automatic int initWaitCycles(input int index, input int code);
        if (code == 'h38)
            return (index == 0) ? longWaitCycles : midWaitCycles;
        if (code == 'h08 || code == 'h0C)
            return shortWaitCycles;
        return longWaitCycles;
    endfunction

    task automatic checkResetOutputs();
        checkValue("lcdEnableOut", 0, int'(lcdEnableOut));
        checkValue("lcdBus", 0, int'(lcdBus));
        checkValue("lcdRsSelect", 0, int'(lcdRsSelect));
        checkValue("lcdReadWriteSel", 0, int'(lcdReadWriteSel));
        checkValue("lcdOnOut", 0, int'(lcdOnOut));
    endtask

    // the gap is only known once the next pulse rises
    task automatic checkCommand(input int index, input int expByte, input int expRs,
                                input int waitCycles);
        wait (gapCount > index);
        checkValue("lcdBus", expByte, int'(capByteQ[index]));
        checkValue("lcdRsSelect", expRs, int'(capRsQ[index]));
        checkValue("enableHighCycles", pulseCycles + 1, highWidthQ[index]);
        // done, issue and setup add three low cycles to the wait
        checkValue("enableLowGap", waitCycles + 3, lowGapQ[index]);
    endtask

    task automatic checkInit(input int firstIndex);
        int code;
        for (int i = 0; i < initCount; i++)
        begin
            code = int'(vectorMem[charCount + i]);
            checkCommand(firstIndex + i, code, 0, initWaitCycles(i, code));
        end
    endtask

    task automatic updateRandomChar();
        lcdPkg::charAddr_t addr;
        lcdPkg::charCode_t code;
        addr = lcdPkg::charAddr_t'($urandom);
        code = lcdPkg::charCode_t'($urandom);
        // the cell has to really change
        if (code == charModel[addr])
            code = ~code;
        @(negedge clk);
        writeAddr <= addr;
        charCode  <= code;
        charModel[addr] = code;
    endtask

    task automatic checkRefreshPass(input int firstIndex, input bit writeUpdate);
        int index;
        int cursor;
        for (int addr = 0; addr < charCount; addr++)
        begin
            index  = firstIndex + 3 * addr;
            cursor = (addr == charCount - 1) ? 'h02 : 'h14;
            checkCommand(index, addressByte(addr), 0, shortWaitCycles);
            checkCommand(index + 1, int'(charModel[addr]), 1, shortWaitCycles);
            // every cell of this pass has been read by now
            if (writeUpdate && addr == charCount - 1)
                updateRandomChar();
            checkCommand(index + 2, cursor, 0, shortWaitCycles);
        end
    endtask

    task automatic resetMidRun(output int firstIndex);
        do
            @(negedge clk);
        while (!lcdEnableOut);
        lcdOnIn <= 1'b0;
        #1;
        checkValue("lcdEnableOut", 0, int'(lcdEnableOut));
        repeat (resetCycles)
        begin
            @(negedge clk);
            checkResetOutputs();
        end
        firstIndex = fallCount;
        lcdOnIn <= 1'b1;
        repeat (powerOnCycles)
        begin
            @(negedge clk);
            checkValue("lcdEnableOut", 0, int'(lcdEnableOut));
        end
    endtask

    // bus monitor sampled on the falling clock edge
    always @(negedge clk)
    begin
        if (!lcdOnIn)
        begin
            // a capture cut short by reset gets no gap
            if (haveFall)
            begin
                lowGapQ.push_back(-1);
                gapCount = gapCount + 1;
            end
            haveFall   = 1'b0;
            enablePrev = 1'b0;
        end
        else if (lcdEnableOut)
        begin
            if (!enablePrev)
            begin
                if (haveFall)
                begin
                    lowGapQ.push_back(lowCount);
                    gapCount = gapCount + 1;
                end
                haveFall  = 1'b0;
                highCount = 0;
            end
            highCount  = highCount + 1;
            enablePrev = 1'b1;
        end
        else
        begin
            if (enablePrev)
            begin
                capByteQ.push_back(lcdBus);
                capRsQ.push_back(lcdRsSelect);
                highWidthQ.push_back(highCount);
                fallCount = fallCount + 1;
                haveFall  = 1'b1;
                lowCount  = 0;
            end
            lowCount   = lowCount + 1;
            enablePrev = 1'b0;
        end
    end

    initial
    begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Run timed out after %0d clock cycles", watchdogCycles);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial
    begin
        int loopCycles;
        int firstIndex;
        lcdOnIn   = 1'b1;
        writeAddr = '0;
        charCode  = '0;
        seedValue = $urandom(32'h3e7ef295);
        $readmemh("testbench/lcdVectors.txt", vectorMem);
        if ($isunknown(vectorMem[charCount]) || vectorMem[charCount] == 8'h00)
        begin
            $display("The vectors file testbench/lcdVectors.txt did not load");
            $display("Test failures found");
            $fatal(1, "no stimulus");
        end
        for (int i = 0; i < charCount; i++)
            charModel[i] = vectorMem[i];
        loopCycles = resetCycles + 1 + powerOnCycles;
        if (loopCycles < charCount)
            loopCycles = charCount;
        // reset, power-on wait and buffer fill overlap
        for (int cycle = 0; cycle < loopCycles; cycle++)
        begin
            @(negedge clk);
            if (cycle == 0)
                lcdOnIn <= 1'b0;
            else if (cycle <= resetCycles)
                checkResetOutputs();
            else if (cycle <= resetCycles + powerOnCycles)
            begin
                checkValue("lcdEnableOut", 0, int'(lcdEnableOut));
                checkValue("lcdOnOut", 1, int'(lcdOnOut));
            end
            if (cycle == resetCycles)
                lcdOnIn <= 1'b1;
            if (cycle < charCount)
            begin
                writeAddr <= lcdPkg::charAddr_t'(cycle);
                charCode  <= charModel[cycle];
            end
        end
        checkInit(0);
        checkRefreshPass(initCount, 1'b0);
        checkRefreshPass(initCount + passCommands, 1'b1);
        checkRefreshPass(initCount + 2 * passCommands, 1'b0);
        resetMidRun(firstIndex);
        checkInit(firstIndex);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
